/* include/graphite_macros.svh */
// graphite rasterizer constants
// frame geometry, field widths and the command word layout

`ifndef GRAPHITE_MACROS_SVH
`define GRAPHITE_MACROS_SVH

// frame size in pixels, addresses are row major
`define FB_WIDTH  32
`define FB_HEIGHT 32

// signed integer coordinate width
`define CORD_W 12

// frame buffer address and pixel widths
`define ADDR_W  16
`define COLOR_W 16

// opcode field in the 32-bit command word
`define OP_POS 28
`define OP_W   4

`endif

/* src/graphite_pkg.sv */
// graphite shared types
// command opcodes, controller states, coordinate and edge value types

`default_nettype none

`include "graphite_macros.svh"

package graphite_pkg;

    typedef enum logic [`OP_W-1:0] {
        OP_SET_X0    = 4'd0,
        OP_SET_Y0    = 4'd1,
        OP_SET_X1    = 4'd2,
        OP_SET_Y1    = 4'd3,
        OP_SET_X2    = 4'd4,
        OP_SET_Y2    = 4'd5,
        OP_SET_COLOR = 4'd6,
        OP_CLEAR     = 4'd7,
        OP_DRAW      = 4'd8,
        OP_SWAP      = 4'd9
    } opcode_e;

    typedef enum logic [2:0] {
        IDLE, DECODE, CLEAR, TRI_LOAD, TRI_EVAL, TRI_WAIT, TRI_WRITE, TRI_NEXT
    } ctrl_state_e;

    typedef logic signed [`CORD_W-1:0] coord_t;
    typedef logic signed [31:0] edge_t;

endpackage

`default_nettype wire

/* src/vertex_regs.sv */
// vertex and color register file
// set commands write one coordinate or the fill color

`default_nettype none

`include "graphite_macros.svh"

module vertex_regs (
    input  wire logic                    clk,
    input  wire logic                    reset_i,
    input  wire logic                    reg_write_i,
    input  wire graphite_pkg::opcode_e   reg_sel_i,
    input  wire logic [15:0]             reg_data_i,
    output graphite_pkg::coord_t         x0_o,
    output graphite_pkg::coord_t         y0_o,
    output graphite_pkg::coord_t         x1_o,
    output graphite_pkg::coord_t         y1_o,
    output graphite_pkg::coord_t         x2_o,
    output graphite_pkg::coord_t         y2_o,
    output logic [`COLOR_W-1:0]          color_o
);
    import graphite_pkg::*;

    coord_t coord_in;

    // coordinates ride in the low payload bits
    assign coord_in = coord_t'(reg_data_i[`CORD_W-1:0]);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            x0_o    <= '0;
            y0_o    <= '0;
            x1_o    <= '0;
            y1_o    <= '0;
            x2_o    <= '0;
            y2_o    <= '0;
            color_o <= '0;
        end else if (reg_write_i) begin
            case (reg_sel_i)
                OP_SET_X0:    x0_o <= coord_in;
                OP_SET_Y0:    y0_o <= coord_in;
                OP_SET_X1:    x1_o <= coord_in;
                OP_SET_Y1:    y1_o <= coord_in;
                OP_SET_X2:    x2_o <= coord_in;
                OP_SET_Y2:    y2_o <= coord_in;
                OP_SET_COLOR: color_o <= reg_data_i[`COLOR_W-1:0];
                // other opcodes never reach the register file
                default: ;
            endcase
        end
    end

endmodule

`default_nettype wire

/* src/edge_eval.sv */
// triangle edge function evaluator
// six products go through one registered multiplier, three edge values
// are formed and the pixel is inside when none of them is negative

`default_nettype none

`include "graphite_macros.svh"

module edge_eval (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  start_i,
    input  wire graphite_pkg::coord_t  px_i,
    input  wire graphite_pkg::coord_t  py_i,
    input  wire graphite_pkg::coord_t  x0_i,
    input  wire graphite_pkg::coord_t  y0_i,
    input  wire graphite_pkg::coord_t  x1_i,
    input  wire graphite_pkg::coord_t  y1_i,
    input  wire graphite_pkg::coord_t  x2_i,
    input  wire graphite_pkg::coord_t  y2_i,
    output logic                       done_o,
    output logic                       inside_o
);
    import graphite_pkg::*;

    logic       busy;
    logic [2:0] cnt;
    coord_t     ax, ay, bx, by;
    edge_t      op_a, op_b;
    edge_t      prod, t0, w0, w1, w2;

    // edge pair for the current product: (v1,v2), (v2,v0), (v0,v1)
    always_comb begin
        case (cnt[2:1])
            2'd0: begin
                ax = x1_i;
                ay = y1_i;
                bx = x2_i;
                by = y2_i;
            end
            2'd1: begin
                ax = x2_i;
                ay = y2_i;
                bx = x0_i;
                by = y0_i;
            end
            default: begin
                ax = x0_i;
                ay = y0_i;
                bx = x1_i;
                by = y1_i;
            end
        endcase
    end

    // even steps take (p.x - a.x)*(b.y - a.y), odd steps (p.y - a.y)*(b.x - a.x)
    always_comb begin
        if (!cnt[0]) begin
            op_a = edge_t'(px_i) - edge_t'(ax);
            op_b = edge_t'(by) - edge_t'(ay);
        end else begin
            op_a = edge_t'(py_i) - edge_t'(ay);
            op_b = edge_t'(bx) - edge_t'(ax);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            busy <= 1'b0;
            cnt  <= '0;
        end else if (start_i) begin
            busy <= 1'b1;
            cnt  <= '0;
        end else if (busy) begin
            cnt <= cnt + 3'd1;
            if (cnt == 3'd6)
                busy <= 1'b0;
        end
    end

    // product pipeline, prod lags the operands by one step
    always_ff @(posedge clk) begin
        prod <= op_a * op_b;
        if (cnt[0])
            t0 <= prod;
        if (cnt == 3'd2)
            w0 <= t0 - prod;
        if (cnt == 3'd4)
            w1 <= t0 - prod;
    end

    // last edge is settled in the done cycle itself
    assign w2       = t0 - prod;
    assign done_o   = busy && (cnt == 3'd6);
    assign inside_o = !w0[31] && !w1[31] && !w2[31];

    // controller must wait for done before the next pixel
    a_no_restart: assert property (@(posedge clk) disable iff (reset_i)
        start_i |-> !busy);

endmodule

`default_nettype wire

/* src/raster_scan.sv */
// bounding box and scan counter
// computes the clipped box of the triangle or the whole frame, then walks
// it row by row while keeping the frame buffer address in step

`default_nettype none

`include "graphite_macros.svh"

module raster_scan (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  load_i,
    input  wire logic                  full_frame_i,
    input  wire logic                  step_i,
    input  wire graphite_pkg::coord_t  x0_i,
    input  wire graphite_pkg::coord_t  y0_i,
    input  wire graphite_pkg::coord_t  x1_i,
    input  wire graphite_pkg::coord_t  y1_i,
    input  wire graphite_pkg::coord_t  x2_i,
    input  wire graphite_pkg::coord_t  y2_i,
    output graphite_pkg::coord_t       x_o,
    output graphite_pkg::coord_t       y_o,
    output logic [`ADDR_W-1:0]         addr_o,
    output logic                       last_o,
    output logic                       empty_o
);
    import graphite_pkg::*;

    localparam coord_t XMAX = coord_t'(`FB_WIDTH - 1);
    localparam coord_t YMAX = coord_t'(`FB_HEIGHT - 1);

    coord_t raw_min_x, raw_max_x, raw_min_y, raw_max_y;
    coord_t new_lo_x, new_hi_x, new_lo_y, new_hi_y;
    logic   new_empty;
    coord_t lo_x_q, hi_x_q, hi_y_q;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    // pin a value into 0..hi
    function automatic coord_t clamp(input coord_t v, input coord_t hi);
        if (v < 0)
            return coord_t'(0);
        else if (v > hi)
            return hi;
        return v;
    endfunction

    assign raw_min_x = min3(x0_i, x1_i, x2_i);
    assign raw_max_x = max3(x0_i, x1_i, x2_i);
    assign raw_min_y = min3(y0_i, y1_i, y2_i);
    assign raw_max_y = max3(y0_i, y1_i, y2_i);

    always_comb begin
        if (full_frame_i) begin
            new_lo_x  = coord_t'(0);
            new_hi_x  = XMAX;
            new_lo_y  = coord_t'(0);
            new_hi_y  = YMAX;
            new_empty = 1'b0;
        end else begin
            new_lo_x  = clamp(raw_min_x, XMAX);
            new_hi_x  = clamp(raw_max_x, XMAX);
            new_lo_y  = clamp(raw_min_y, YMAX);
            new_hi_y  = clamp(raw_max_y, YMAX);
            new_empty = (raw_max_x < 0) || (raw_min_x > XMAX) ||
                        (raw_max_y < 0) || (raw_min_y > YMAX);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            x_o     <= '0;
            y_o     <= '0;
            addr_o  <= '0;
            lo_x_q  <= '0;
            hi_x_q  <= '0;
            hi_y_q  <= '0;
            empty_o <= 1'b0;
        end else if (load_i) begin
            x_o     <= new_lo_x;
            y_o     <= new_lo_y;
            addr_o  <= `ADDR_W'(new_lo_y) * `ADDR_W'(`FB_WIDTH) + `ADDR_W'(new_lo_x);
            lo_x_q  <= new_lo_x;
            hi_x_q  <= new_hi_x;
            hi_y_q  <= new_hi_y;
            empty_o <= new_empty;
        end else if (step_i) begin
            if (x_o == hi_x_q) begin
                // jump over the part of the row outside the box
                x_o    <= lo_x_q;
                y_o    <= y_o + coord_t'(1);
                addr_o <= addr_o + `ADDR_W'(`FB_WIDTH) - `ADDR_W'(hi_x_q) + `ADDR_W'(lo_x_q);
            end else begin
                x_o    <= x_o + coord_t'(1);
                addr_o <= addr_o + `ADDR_W'(1);
            end
        end
    end

    assign last_o = (x_o == hi_x_q) && (y_o == hi_y_q);

    // steps past the last pixel would leave the frame
    a_addr_in_frame: assert property (@(posedge clk) disable iff (reset_i)
        (load_i || step_i) |=> (empty_o || addr_o < `FB_WIDTH * `FB_HEIGHT));

endmodule

`default_nettype wire

/* src/raster_ctrl.sv */
// command controller
// accepts commands, updates the register file, runs clears and triangle
// fills and drives the frame buffer write port

`default_nettype none

`include "graphite_macros.svh"

module raster_ctrl (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  cmd_valid_i,
    output logic                       cmd_ready_o,
    input  wire logic [31:0]           cmd_data_i,
    output logic                       reg_write_o,
    output graphite_pkg::opcode_e      reg_sel_o,
    output logic [15:0]                reg_data_o,
    output logic                       scan_load_o,
    output logic                       full_frame_o,
    output logic                       scan_step_o,
    input  wire logic                  last_i,
    input  wire logic                  empty_i,
    output logic                       eval_start_o,
    input  wire logic                  eval_done_i,
    input  wire logic                  inside_i,
    input  wire logic [`COLOR_W-1:0]   color_i,
    input  wire logic [`ADDR_W-1:0]    addr_i,
    output logic                       vram_wr_o,
    output logic [`ADDR_W-1:0]         vram_addr_o,
    output logic [`COLOR_W-1:0]        vram_data_o,
    output logic                       swap_o
);
    import graphite_pkg::*;

    ctrl_state_e state;
    opcode_e     cmd_op;
    opcode_e     op_q;
    logic [15:0] data_q;
    logic        accept;

    assign cmd_op      = opcode_e'(cmd_data_i[`OP_POS +: `OP_W]);
    assign cmd_ready_o = (state == IDLE);
    assign accept      = cmd_valid_i && cmd_ready_o;

    // latched command drives the register file for one cycle
    assign reg_sel_o  = op_q;
    assign reg_data_o = data_q;

    assign scan_load_o  = (state == DECODE) && (op_q == OP_CLEAR || op_q == OP_DRAW);
    assign full_frame_o = (op_q == OP_CLEAR);

    // never step beyond the last pixel of the box
    assign scan_step_o  = (state == CLEAR || state == TRI_NEXT) && !last_i;
    assign eval_start_o = (state == TRI_EVAL);

    // the memory takes a write every cycle, so the port follows the scanner
    assign vram_wr_o   = (state == CLEAR) || (state == TRI_WRITE);
    assign vram_addr_o = addr_i;
    assign vram_data_o = color_i;

    always_ff @(posedge clk) begin
        if (accept) begin
            op_q   <= cmd_op;
            data_q <= cmd_data_i[15:0];
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state       <= IDLE;
            reg_write_o <= 1'b0;
            swap_o      <= 1'b0;
        end else begin
            // set opcodes occupy the low end of the code space
            reg_write_o <= accept && (cmd_op <= OP_SET_COLOR);
            swap_o      <= accept && (cmd_op == OP_SWAP);

            case (state)
                IDLE: begin
                    if (accept)
                        state <= DECODE;
                end
                DECODE: begin
                    case (op_q)
                        OP_CLEAR: state <= CLEAR;
                        OP_DRAW:  state <= TRI_LOAD;
                        default:  state <= IDLE;
                    endcase
                end
                CLEAR: begin
                    if (last_i)
                        state <= IDLE;
                end
                TRI_LOAD: begin
                    // box is ready, nothing to do when it misses the frame
                    if (empty_i)
                        state <= IDLE;
                    else
                        state <= TRI_EVAL;
                end
                TRI_EVAL: begin
                    state <= TRI_WAIT;
                end
                TRI_WAIT: begin
                    if (eval_done_i)
                        state <= inside_i ? TRI_WRITE : TRI_NEXT;
                end
                TRI_WRITE: begin
                    state <= TRI_NEXT;
                end
                TRI_NEXT: begin
                    if (last_i)
                        state <= IDLE;
                    else
                        state <= TRI_EVAL;
                end
                default: begin
                    state <= IDLE;
                end
            endcase
        end
    end

    // the evaluator only reports while the FSM waits for its verdict
    a_done_in_wait: assert property (@(posedge clk) disable iff (reset_i)
        eval_done_i |-> (state == TRI_WAIT));

endmodule

`default_nettype wire

/* src/graphite_top.sv */
// graphite triangle rasterizer top level
// command stream in, frame buffer writes and swap pulse out

`default_nettype none

`include "graphite_macros.svh"

module graphite_top (
    input  wire logic                  clk,
    input  wire logic                  reset_i,
    input  wire logic                  cmd_valid_i,
    output logic                       cmd_ready_o,
    input  wire logic [31:0]           cmd_data_i,
    output logic                       vram_wr_o,
    output logic [`ADDR_W-1:0]         vram_addr_o,
    output logic [`COLOR_W-1:0]        vram_data_o,
    output logic                       swap_o
);
    import graphite_pkg::*;

    logic                reg_write;
    opcode_e             reg_sel;
    logic [15:0]         reg_data;
    coord_t              x0, y0, x1, y1, x2, y2;
    logic [`COLOR_W-1:0] color;
    logic                scan_load, full_frame, scan_step;
    coord_t              scan_x, scan_y;
    logic [`ADDR_W-1:0]  scan_addr;
    logic                scan_last, scan_empty;
    logic                eval_start, eval_done, eval_inside;

    vertex_regs vertex_regs_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .reg_write_i (reg_write),
        .reg_sel_i   (reg_sel),
        .reg_data_i  (reg_data),
        .x0_o        (x0),
        .y0_o        (y0),
        .x1_o        (x1),
        .y1_o        (y1),
        .x2_o        (x2),
        .y2_o        (y2),
        .color_o     (color)
    );

    raster_scan raster_scan_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .load_i       (scan_load),
        .full_frame_i (full_frame),
        .step_i       (scan_step),
        .x0_i         (x0),
        .y0_i         (y0),
        .x1_i         (x1),
        .y1_i         (y1),
        .x2_i         (x2),
        .y2_i         (y2),
        .x_o          (scan_x),
        .y_o          (scan_y),
        .addr_o       (scan_addr),
        .last_o       (scan_last),
        .empty_o      (scan_empty)
    );

    // evaluator works on the pixel the scanner points at
    edge_eval edge_eval_inst (
        .clk      (clk),
        .reset_i  (reset_i),
        .start_i  (eval_start),
        .px_i     (scan_x),
        .py_i     (scan_y),
        .x0_i     (x0),
        .y0_i     (y0),
        .x1_i     (x1),
        .y1_i     (y1),
        .x2_i     (x2),
        .y2_i     (y2),
        .done_o   (eval_done),
        .inside_o (eval_inside)
    );

    raster_ctrl raster_ctrl_inst (
        .clk          (clk),
        .reset_i      (reset_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_ready_o  (cmd_ready_o),
        .cmd_data_i   (cmd_data_i),
        .reg_write_o  (reg_write),
        .reg_sel_o    (reg_sel),
        .reg_data_o   (reg_data),
        .scan_load_o  (scan_load),
        .full_frame_o (full_frame),
        .scan_step_o  (scan_step),
        .last_i       (scan_last),
        .empty_i      (scan_empty),
        .eval_start_o (eval_start),
        .eval_done_i  (eval_done),
        .inside_i     (eval_inside),
        .color_i      (color),
        .addr_i       (scan_addr),
        .vram_wr_o    (vram_wr_o),
        .vram_addr_o  (vram_addr_o),
        .vram_data_o  (vram_data_o),
        .swap_o       (swap_o)
    );

endmodule

`default_nettype wire

/* bench/graphite_tb.sv */
// graphite rasterizer testbench
// replays the command file, mirrors frame buffer writes into a shadow frame
// and compares it with a reference frame built from the fill rules

`default_nettype none

`include "graphite_macros.svh"

module graphite_tb;

    localparam int FRAME_PIXELS = `FB_WIDTH * `FB_HEIGHT;
    localparam int CLK_HALF     = 20;

    logic                clk;
    logic                reset_i;
    logic                cmd_valid_i;
    logic                cmd_ready_o;
    logic [31:0]         cmd_data_i;
    logic                vram_wr_o;
    logic [`ADDR_W-1:0]  vram_addr_o;
    logic [`COLOR_W-1:0] vram_data_o;
    logic                swap_o;

    // parsed data file
    byte  line_kind[$];
    int   line_a[$];
    int   line_b[$];
    int   line_c[$];

    logic [15:0] shadow_frame[FRAME_PIXELS];
    logic [15:0] ref_frame[FRAME_PIXELS];
    bit          written[FRAME_PIXELS];

    // reference copies of the register file
    int          ref_x[3];
    int          ref_y[3];
    logic [15:0] ref_color;

    int   cycle_count;
    int   cycle_limit;
    int   monitor_cycle;
    int   write_count;
    int   swap_count;
    int   error_count;
    bit   clear_active;
    int   next_clear_addr;
    int   last_write_cycle;
    logic [15:0] clear_color;

    graphite_top graphite_top_inst (
        .clk         (clk),
        .reset_i     (reset_i),
        .cmd_valid_i (cmd_valid_i),
        .cmd_ready_o (cmd_ready_o),
        .cmd_data_i  (cmd_data_i),
        .vram_wr_o   (vram_wr_o),
        .vram_addr_o (vram_addr_o),
        .vram_data_o (vram_data_o),
        .swap_o      (swap_o)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF clk = ~clk;
        end
    end

    task automatic stop_run(input string msg);
        error_count++;
        $display("%s", msg);
        $display("Done: errors found");
        $fatal(1, "stopping at first error");
    endtask

    task automatic compare_value(input string name, input int got, input int exp);
        string msg;
        assert (got == exp) else begin
            msg = $sformatf("ERR t=%0t %s got %0h expected %0h", $time, name, got, exp);
            stop_run(msg);
        end
    endtask

    function automatic int payload_coord(input logic [31:0] cmd);
        int v;
        v = int'(cmd[11:0]);
        if (cmd[11])
            v = v - 4096;
        return v;
    endfunction

    // edge value of pixel p against the edge from a to b
    function automatic int edge_value(input int px, input int py, input int ax,
                                      input int ay, input int bx, input int by);
        return (px - ax) * (by - ay) - (py - ay) * (bx - ax);
    endfunction

    function automatic int clip(input int v, input int hi);
        if (v < 0)
            return 0;
        if (v > hi)
            return hi;
        return v;
    endfunction

    // fill the reference frame over the clipped box of the current triangle
    task automatic draw_reference();
        int lo_x;
        int hi_x;
        int lo_y;
        int hi_y;
        int e0;
        int e1;
        int e2;
        lo_x = ref_x[0];
        hi_x = ref_x[0];
        lo_y = ref_y[0];
        hi_y = ref_y[0];
        for (int i = 1; i < 3; i++) begin
            if (ref_x[i] < lo_x) lo_x = ref_x[i];
            if (ref_x[i] > hi_x) hi_x = ref_x[i];
            if (ref_y[i] < lo_y) lo_y = ref_y[i];
            if (ref_y[i] > hi_y) hi_y = ref_y[i];
        end
        if (hi_x < 0 || lo_x >= `FB_WIDTH || hi_y < 0 || lo_y >= `FB_HEIGHT)
            return;
        for (int y = clip(lo_y, `FB_HEIGHT - 1); y <= clip(hi_y, `FB_HEIGHT - 1); y++) begin
            for (int x = clip(lo_x, `FB_WIDTH - 1); x <= clip(hi_x, `FB_WIDTH - 1); x++) begin
                e0 = edge_value(x, y, ref_x[1], ref_y[1], ref_x[2], ref_y[2]);
                e1 = edge_value(x, y, ref_x[2], ref_y[2], ref_x[0], ref_y[0]);
                e2 = edge_value(x, y, ref_x[0], ref_y[0], ref_x[1], ref_y[1]);
                if (e0 >= 0 && e1 >= 0 && e2 >= 0)
                    ref_frame[y * `FB_WIDTH + x] = ref_color;
            end
        end
    endtask

    // offer one command, hold it until accepted, then update the reference
    task automatic send_command(input logic [31:0] cmd);
        logic [3:0] op;
        bit         rdy;
        int         cycles;
        int         writes_before;
        int         swaps_before;
        op = cmd[`OP_POS +: `OP_W];
        cmd_valid_i = 1'b1;
        cmd_data_i  = cmd;
        do begin
            rdy = cmd_ready_o;
            @(posedge clk);
            #2;
        end while (!rdy);
        cmd_valid_i = 1'b0;
        writes_before = write_count;
        swaps_before  = swap_count;
        if (op <= 4'd5) begin
            if (op[0])
                ref_y[op / 2] = payload_coord(cmd);
            else
                ref_x[op / 2] = payload_coord(cmd);
        end else if (op == 4'd6) begin
            ref_color = cmd[15:0];
        end
        if (op == 4'd7) begin
            written = '{default: 1'b0};
            ref_frame = '{default: ref_color};
            clear_color = ref_color;
            next_clear_addr = 0;
            clear_active = 1'b1;
        end else if (op == 4'd8) begin
            written = '{default: 1'b0};
            draw_reference();
        end else begin
            // short commands finish on their own, check their timing here
            cycles = 1;
            while (!cmd_ready_o) begin
                @(posedge clk);
                #2;
                cycles++;
            end
            compare_value("cmd_ready_o latency", cycles, 2);
            compare_value("writes during short command", write_count, writes_before);
            compare_value("swap_o pulses", swap_count, swaps_before + (op == 4'd9));
        end
    endtask

    task automatic check_frame();
        for (int i = 0; i < FRAME_PIXELS; i++)
            compare_value($sformatf("shadow pixel %0d", i), shadow_frame[i], ref_frame[i]);
    endtask

    // write monitor
    always @(posedge clk) begin
        monitor_cycle++;
        if (!reset_i) begin
            if (swap_o)
                swap_count++;
            if (vram_wr_o) begin
                assert (vram_addr_o < FRAME_PIXELS) else
                    stop_run($sformatf("write to address %0d outside the frame", vram_addr_o));
                assert (!written[vram_addr_o]) else
                    stop_run($sformatf("address %0d written twice in one command", vram_addr_o));
                if (clear_active) begin
                    compare_value("vram_addr_o", vram_addr_o, next_clear_addr);
                    compare_value("vram_data_o", vram_data_o, clear_color);
                    if (next_clear_addr > 0)
                        compare_value("clear write cycle", monitor_cycle, last_write_cycle + 1);
                    next_clear_addr++;
                    if (next_clear_addr == FRAME_PIXELS)
                        clear_active = 1'b0;
                end
                written[vram_addr_o]      = 1'b1;
                shadow_frame[vram_addr_o] = vram_data_o;
                last_write_cycle          = monitor_cycle;
                write_count++;
            end
        end
    end

    // timeout
    always @(posedge clk) begin
        cycle_count++;
        if (cycle_limit > 0 && cycle_count > cycle_limit) begin
            $display("run did not finish within %0d cycles", cycle_limit);
            $display("Done: errors found");
            $fatal(1, "timeout");
        end
    end

    initial begin
        int    fd;
        int    n;
        int    a;
        int    b;
        int    c;
        int    expected_writes;
        int    clears;
        byte   kind;
        string line;
        void'($urandom(32'h61a3));
        reset_i = 1'b1;
        cmd_valid_i = 1'b0;
        cmd_data_i = '0;
        cycle_count = 0;
        cycle_limit = 0;
        monitor_cycle = 0;
        write_count = 0;
        swap_count = 0;
        error_count = 0;
        clear_active = 1'b0;
        next_clear_addr = 0;
        last_write_cycle = 0;
        clear_color = '0;
        expected_writes = 0;
        clears = 0;
        ref_x = '{0, 0, 0};
        ref_y = '{0, 0, 0};
        ref_color = '0;
        shadow_frame = '{default: 16'h0};
        ref_frame = '{default: 16'h0};
        written = '{default: 1'b0};

        fd = $fopen("bench/graphite_input.txt", "r");
        if (fd == 0)
            stop_run("cannot open bench/graphite_input.txt");
        while ($fgets(line, fd)) begin
            n = $sscanf(line, "%c", kind);
            if (n == 1 && (kind == "C" || kind == "N" || kind == "P")) begin
                a = 0;
                b = 0;
                c = 0;
                if (kind == "C")
                    n = $sscanf(line, "%c %h", kind, a);
                else if (kind == "N")
                    n = $sscanf(line, "%c %d", kind, a);
                else
                    n = $sscanf(line, "%c %d %d %h", kind, a, b, c);
                if (kind == "C" && a[31:28] == 4'd7)
                    clears++;
                line_kind.push_back(kind);
                line_a.push_back(a);
                line_b.push_back(b);
                line_c.push_back(c);
            end
        end
        $fclose(fd);
        cycle_limit = 2000 * line_kind.size() + 1200 * clears;

        repeat (5) @(posedge clk);
        #2;
        reset_i = 1'b0;
        compare_value("cmd_ready_o", cmd_ready_o, 1);
        compare_value("vram_wr_o", vram_wr_o, 0);
        compare_value("swap_o", swap_o, 0);

        for (int i = 0; i < line_kind.size(); i++) begin
            if (line_kind[i] == "C") begin
                send_command(line_a[i]);
                if (line_a[i][31:28] == 4'd9) begin
                    compare_value("write count", write_count, expected_writes);
                    check_frame();
                    write_count = 0;
                end
                n = $urandom % 4;
                repeat (n) begin
                    @(posedge clk);
                    #2;
                end
            end else if (line_kind[i] == "N") begin
                expected_writes = line_a[i];
            end else begin
                a = line_b[i] * `FB_WIDTH + line_a[i];
                compare_value($sformatf("shadow pixel %0d,%0d", line_a[i], line_b[i]),
                              shadow_frame[a], line_c[i]);
                compare_value($sformatf("reference pixel %0d,%0d", line_a[i], line_b[i]),
                              ref_frame[a], line_c[i]);
            end
        end

        while (!cmd_ready_o) begin
            @(posedge clk);
            #2;
        end
        if (error_count == 0) begin
            $display("Done: no errors");
            $finish;
        end else begin
            $display("Done: errors found");
            $fatal(1, "checks failed");
        end
    end

endmodule

`default_nettype wire

/* bench/graphite_input.txt */
# C <command word, hex> | N <writes expected up to the next swap, decimal>
# P <x> <y> <expected color, hex> checked after the preceding swap
C 60001234
C 70000000
N 1024
C 90000000
P 0 0 1234
P 31 31 1234
C 60000F0F
C 00000002
C 10000003
C 20000002
C 30000007
C 40000006
C 50000003
C 80000000
C F0000000
C 60000ABC
C 20000006
C 30000003
C 40000002
C 50000007
C 80000000
N 15
C 90000000
P 2 3 0F0F
P 4 5 0F0F
P 5 5 1234
P 6 3 0F0F
P 2 7 0F0F
P 3 7 1234
C 00000FFE
C 10000FFE
C 20000FFE
C 30000006
C 40000006
C 50000FFE
C 80000000
C 0000001C
C 1000001C
C 2000001C
C 30000024
C 40000024
C 5000001C
C 80000000
C 00000028
C 10000028
C 20000028
C 3000002C
C 4000002C
C 50000028
C 80000000
C 0000000A
C 10000014
C 2000000C
C 30000014
C 4000000E
C 50000014
C 80000000
N 36
C 90000000
P 0 0 0ABC
P 4 0 0ABC
P 5 0 1234
P 0 4 0ABC
P 2 3 0F0F
P 31 31 0ABC
P 28 31 0ABC
P 12 20 0ABC
P 15 20 1234

/* project.f */
+incdir+include
src/graphite_pkg.sv
src/vertex_regs.sv
src/edge_eval.sv
src/raster_scan.sv
src/raster_ctrl.sv
src/graphite_top.sv
bench/graphite_tb.sv
